// File: src.f
src/core_sched_pkg.sv
src/app_table.sv
src/core_load_state.sv
src/request_decode.sv
src/min_tree.sv
src/dispatch_result.sv
src/core_sched.sv
sim/clk_rst_gen.sv
sim/core_sched_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --timing --timescale 1ns/100ps -Wno-fatal \
    --top-module core_sched_tb -f src.f -o core_sched_tb_sim

status=0
./obj_dir/core_sched_tb_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "RESULT: PASS" sim.log; then
    echo "simulation did not complete"
    exit 1
fi
echo "simulation completed without errors"

// File: sim/core_sched_tb.sv
`default_nettype none

module core_sched_tb;
    timeunit 1ns;
    timeprecision 100ps;

    typedef enum logic [2:0] {
        OP_CFG,
        OP_CORE_CTL,
        OP_DEQ,
        OP_REQ,
        OP_RANK,
        OP_IDLE,
        OP_MASK
    } tb_op_e;

    localparam int DRIVE_DELAY    = 2;
    localparam int RESULT_TIMEOUT = 20;
    localparam int RESET_TIMEOUT  = 50;

    logic                       clk;
    logic                       rst;
    logic                       cfg_valid;
    core_sched_pkg::app_id_t    cfg_app_id;
    core_sched_pkg::core_id_t   cfg_core_id;
    logic                       cfg_enable;
    logic                       core_ctl_valid;
    core_sched_pkg::core_id_t   core_ctl_core_id;
    logic                       core_ctl_activate;
    logic                       deq_valid;
    core_sched_pkg::core_id_t   deq_core_id;
    core_sched_pkg::load_t      deq_length;
    logic                       req_en;
    core_sched_pkg::app_id_t    req_app_id;
    core_sched_pkg::load_t      rank_bound;
    logic                       result_en;
    core_sched_pkg::core_id_t   result_core_id;
    core_sched_pkg::load_t      result_load;
    core_sched_pkg::app_id_t    result_app_id;
    core_sched_pkg::app_mask_t  app_mask;

    // row table with one entry per row in every queue
    tb_op_e op_q[$];
    int     app_q[$];
    int     core_q[$];
    // enable, activate, length, request count, bound or cycle count
    int     val_q[$];
    int     exp_core_q[$];
    int     exp_load_q[$];
    int     exp_mask_q[$];
    string  name_q[$];

    clk_rst_gen u_clk_rst_gen (
        .clk (clk),
        .rst (rst)
    );

    core_sched u_core_sched (.*);

    task automatic add_row(tb_op_e op, int app, int core, int val,
                           int exp_core, int exp_load, int exp_mask, string name);
        op_q.push_back(op);
        app_q.push_back(app);
        core_q.push_back(core);
        val_q.push_back(val);
        exp_core_q.push_back(exp_core);
        exp_load_q.push_back(exp_load);
        exp_mask_q.push_back(exp_mask);
        name_q.push_back(name);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic stop_with_failure();
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_core(string name, core_sched_pkg::core_id_t exp,
                              core_sched_pkg::core_id_t act);
        if (act !== exp) begin
            $display("MISMATCH %s core: expected %0d, actual %0d", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_load(string name, core_sched_pkg::load_t exp,
                              core_sched_pkg::load_t act);
        if (act !== exp) begin
            $display("MISMATCH %s load: expected %0d, actual %0d", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_app_id(string name, core_sched_pkg::app_id_t exp,
                                core_sched_pkg::app_id_t act);
        if (act !== exp) begin
            $display("MISMATCH %s app: expected %0d, actual %0d", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_app_mask(string name, core_sched_pkg::app_mask_t exp,
                                  core_sched_pkg::app_mask_t act);
        if (act !== exp) begin
            $display("MISMATCH %s app_mask: expected 0x%02h, actual 0x%02h", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic expect_no_result(string name);
        if (result_en !== 1'b0) begin
            $display("ERROR %s: result_en is high when no result is due", name);
            stop_with_failure();
        end
    endtask

    // back to back requests when the count is above one
    task automatic run_request(int r);
        int waited;

        req_app_id = core_sched_pkg::app_id_t'(app_q[r]);
        req_en     = 1'b1;
        repeat (val_q[r]) next_cycle();
        req_en = 1'b0;
        waited = 0;
        while (result_en !== 1'b1) begin
            if (waited == RESULT_TIMEOUT) begin
                $display("ERROR %s: no result arrived within %0d cycles",
                         name_q[r], RESULT_TIMEOUT);
                stop_with_failure();
            end
            waited++;
            next_cycle();
        end
        for (int i = 0; i < val_q[r]; i++) begin
            if (result_en !== 1'b1) begin
                $display("ERROR %s: result %0d did not follow on the next cycle", name_q[r], i);
                stop_with_failure();
            end
            check_core(name_q[r], core_sched_pkg::core_id_t'(exp_core_q[r]), result_core_id);
            check_load(name_q[r], core_sched_pkg::load_t'(exp_load_q[r]), result_load);
            check_app_id(name_q[r], core_sched_pkg::app_id_t'(app_q[r]), result_app_id);
            next_cycle();
        end
        // single cycle pulse, and the last increment has reached its counter
        expect_no_result(name_q[r]);
    endtask

    task automatic apply_row(int r);
        case (op_q[r])
            OP_CFG: begin
                cfg_valid   = 1'b1;
                cfg_app_id  = core_sched_pkg::app_id_t'(app_q[r]);
                cfg_core_id = core_sched_pkg::core_id_t'(core_q[r]);
                cfg_enable  = (val_q[r] != 0);
                next_cycle();
                cfg_valid = 1'b0;
            end
            OP_CORE_CTL: begin
                core_ctl_valid    = 1'b1;
                core_ctl_core_id  = core_sched_pkg::core_id_t'(core_q[r]);
                core_ctl_activate = (val_q[r] != 0);
                next_cycle();
                core_ctl_valid = 1'b0;
            end
            OP_DEQ: begin
                deq_valid   = 1'b1;
                deq_core_id = core_sched_pkg::core_id_t'(core_q[r]);
                deq_length  = core_sched_pkg::load_t'(val_q[r]);
                next_cycle();
                deq_valid = 1'b0;
            end
            OP_REQ: run_request(r);
            OP_RANK: begin
                rank_bound = core_sched_pkg::load_t'(val_q[r]);
                next_cycle();
            end
            OP_IDLE, OP_MASK: begin
                for (int i = 0; i < val_q[r]; i++) begin
                    expect_no_result(name_q[r]);
                    if (op_q[r] == OP_MASK) begin
                        check_app_mask(name_q[r], core_sched_pkg::app_mask_t'(exp_mask_q[r]),
                                       app_mask);
                    end
                    next_cycle();
                end
            end
            default: begin
                $display("ERROR row %0d has an unknown kind", r);
                stop_with_failure();
            end
        endcase
    endtask

    initial begin
        int n;

        cfg_valid         = 1'b0;
        cfg_app_id        = '0;
        cfg_core_id       = '0;
        cfg_enable        = 1'b0;
        core_ctl_valid    = 1'b0;
        core_ctl_core_id  = '0;
        core_ctl_activate = 1'b0;
        deq_valid         = 1'b0;
        deq_core_id       = '0;
        deq_length        = '0;
        req_en            = 1'b0;
        req_app_id        = '0;
        rank_bound        = '0;

        //      kind         app core val ecore eload emask name
        add_row(OP_MASK,     0, 0,  10,  0, 0,   8'h00, "reset_quiet");
        add_row(OP_CORE_CTL, 0, 2,  1,   0, 0,   0,     "act_core2");
        add_row(OP_CORE_CTL, 0, 5,  1,   0, 0,   0,     "act_core5");
        add_row(OP_CORE_CTL, 0, 9,  1,   0, 0,   0,     "act_core9");
        add_row(OP_CFG,      1, 2,  1,   0, 0,   0,     "allow_app1_core2");
        add_row(OP_CFG,      1, 5,  1,   0, 0,   0,     "allow_app1_core5");
        add_row(OP_CFG,      1, 9,  1,   0, 0,   0,     "allow_app1_core9");
        add_row(OP_REQ,      1, 0,  1,   2, 0,   0,     "tie_low_index");
        add_row(OP_REQ,      1, 0,  1,   5, 0,   0,     "second_core");
        add_row(OP_REQ,      1, 0,  1,   9, 0,   0,     "third_core");
        add_row(OP_REQ,      1, 0,  1,   2, 1,   0,     "all_loaded_once");
        add_row(OP_DEQ,      0, 5,  1,   0, 0,   0,     "deq_core5");
        add_row(OP_REQ,      1, 0,  1,   5, 0,   0,     "after_dequeue");
        add_row(OP_DEQ,      0, 9,  200, 0, 0,   0,     "deq_core9_big");
        add_row(OP_REQ,      1, 0,  1,   9, 0,   0,     "dequeue_saturates");
        add_row(OP_DEQ,      0, 2,  2,   0, 0,   0,     "deq_core2");
        add_row(OP_CORE_CTL, 0, 2,  0,   0, 0,   0,     "deact_core2");
        add_row(OP_REQ,      1, 0,  1,   5, 1,   0,     "inactive_skipped");
        add_row(OP_CFG,      3, 2,  1,   0, 0,   0,     "allow_app3_core2");
        add_row(OP_CFG,      3, 12, 1,   0, 0,   0,     "allow_app3_core12");
        // core 0 is where an empty choice lands, so it must be active to show a charge
        add_row(OP_CORE_CTL, 0, 0,  1,   0, 0,   0,     "act_core0");
        add_row(OP_CFG,      2, 0,  1,   0, 0,   0,     "allow_app2_core0");
        add_row(OP_REQ,      3, 0,  1,   0, 255, 0,     "no_active_core");
        add_row(OP_REQ,      3, 0,  1,   0, 255, 0,     "no_active_core_again");
        add_row(OP_REQ,      2, 0,  1,   0, 0,   0,     "core0_not_charged");
        add_row(OP_REQ,      1, 0,  1,   9, 1,   0,     "no_stray_increment");
        add_row(OP_RANK,     0, 0,  1,   0, 0,   0,     "rank_one");
        add_row(OP_CORE_CTL, 0, 2,  1,   0, 0,   0,     "react_core2");
        add_row(OP_IDLE,     0, 0,  3,   0, 0,   0,     "settle_set");
        add_row(OP_MASK,     0, 0,  1,   0, 0,   8'h0a, "rank_mask_set");
        add_row(OP_REQ,      1, 0,  1,   2, 0,   0,     "rank_pick");
        add_row(OP_IDLE,     0, 0,  3,   0, 0,   0,     "settle_clear");
        add_row(OP_MASK,     0, 0,  1,   0, 0,   8'h00, "rank_mask_clear");
        add_row(OP_REQ,      1, 0,  2,   2, 1,   0,     "back_to_back");
        add_row(OP_REQ,      1, 0,  1,   5, 2,   0,     "after_back_to_back");

        // rst is sampled on the edge, where it is stable
        n = 0;
        @(posedge clk);
        while (rst !== 1'b0) begin
            if (n == RESET_TIMEOUT) begin
                $display("ERROR reset was not released within %0d cycles", RESET_TIMEOUT);
                stop_with_failure();
            end
            n++;
            @(posedge clk);
        end
        #DRIVE_DELAY;

        for (int r = 0; r < op_q.size(); r++) begin
            apply_row(r);
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/clk_rst_gen.sv
`default_nettype none

module clk_rst_gen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 5;

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

    // released a little after the edge, like every other driven input
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: src/core_sched.sv
`default_nettype none

module core_sched (
    input  wire                             clk,
    input  wire                             rst,

    input  wire                             cfg_valid,
    input  wire core_sched_pkg::app_id_t    cfg_app_id,
    input  wire core_sched_pkg::core_id_t   cfg_core_id,
    input  wire                             cfg_enable,

    input  wire                             core_ctl_valid,
    input  wire core_sched_pkg::core_id_t   core_ctl_core_id,
    input  wire                             core_ctl_activate,

    input  wire                             deq_valid,
    input  wire core_sched_pkg::core_id_t   deq_core_id,
    input  wire core_sched_pkg::load_t      deq_length,

    input  wire                             req_en,
    input  wire core_sched_pkg::app_id_t    req_app_id,

    input  wire core_sched_pkg::load_t      rank_bound,

    output logic                            result_en,
    output core_sched_pkg::core_id_t        result_core_id,
    output core_sched_pkg::load_t           result_load,
    output core_sched_pkg::app_id_t         result_app_id,

    output core_sched_pkg::app_mask_t       app_mask
);

    core_sched_pkg::app_id_t    lookup_app_id;
    core_sched_pkg::core_mask_t lookup_mask;
    core_sched_pkg::core_mask_t eligible;
    core_sched_pkg::load_vec_t  loads;

    logic                       dec_valid;
    core_sched_pkg::app_id_t    dec_app_id;
    core_sched_pkg::load_vec_t  dec_loads;

    logic                       tree_valid;
    core_sched_pkg::app_id_t    tree_app_id;
    core_sched_pkg::core_id_t   tree_core_id;
    core_sched_pkg::load_t      tree_load;

    // feedback from the result stage to the counters
    logic                       inc_valid;
    core_sched_pkg::core_id_t   inc_core_id;

    app_table u_app_table (
        .clk           (clk),
        .rst           (rst),
        .cfg_valid     (cfg_valid),
        .cfg_app_id    (cfg_app_id),
        .cfg_core_id   (cfg_core_id),
        .cfg_enable    (cfg_enable),
        .lookup_app_id (lookup_app_id),
        .lookup_mask   (lookup_mask),
        .eligible      (eligible),
        .app_mask      (app_mask)
    );

    core_load_state u_core_load_state (
        .clk               (clk),
        .rst               (rst),
        .core_ctl_valid    (core_ctl_valid),
        .core_ctl_core_id  (core_ctl_core_id),
        .core_ctl_activate (core_ctl_activate),
        .deq_valid         (deq_valid),
        .deq_core_id       (deq_core_id),
        .deq_length        (deq_length),
        .inc_valid         (inc_valid),
        .inc_core_id       (inc_core_id),
        .rank_bound        (rank_bound),
        .loads             (loads),
        .eligible          (eligible)
    );

    request_decode u_request_decode (
        .clk           (clk),
        .rst           (rst),
        .req_en        (req_en),
        .req_app_id    (req_app_id),
        .lookup_app_id (lookup_app_id),
        .lookup_mask   (lookup_mask),
        .loads         (loads),
        .dec_valid     (dec_valid),
        .dec_app_id    (dec_app_id),
        .dec_loads     (dec_loads)
    );

    min_tree u_min_tree (
        .clk          (clk),
        .rst          (rst),
        .dec_valid    (dec_valid),
        .dec_app_id   (dec_app_id),
        .dec_loads    (dec_loads),
        .tree_valid   (tree_valid),
        .tree_app_id  (tree_app_id),
        .tree_core_id (tree_core_id),
        .tree_load    (tree_load)
    );

    dispatch_result u_dispatch_result (
        .clk            (clk),
        .rst            (rst),
        .tree_valid     (tree_valid),
        .tree_app_id    (tree_app_id),
        .tree_core_id   (tree_core_id),
        .tree_load      (tree_load),
        .result_en      (result_en),
        .result_core_id (result_core_id),
        .result_load    (result_load),
        .result_app_id  (result_app_id),
        .inc_valid      (inc_valid),
        .inc_core_id    (inc_core_id)
    );

endmodule

`default_nettype wire

// File: src/dispatch_result.sv
`default_nettype none

module dispatch_result (
    input  wire                             clk,
    input  wire                             rst,

    input  wire                             tree_valid,
    input  wire core_sched_pkg::app_id_t    tree_app_id,
    input  wire core_sched_pkg::core_id_t   tree_core_id,
    input  wire core_sched_pkg::load_t      tree_load,

    output logic                            result_en,
    output core_sched_pkg::core_id_t        result_core_id,
    output core_sched_pkg::load_t           result_load,
    output core_sched_pkg::app_id_t         result_app_id,

    output logic                            inc_valid,
    output core_sched_pkg::core_id_t        inc_core_id
);

    always_ff @(posedge clk) begin
        if (rst) begin
            result_en <= 1'b0;
            inc_valid <= 1'b0;
        end else begin
            result_en <= tree_valid;
            // max load means no allowed core was active, nothing to charge
            inc_valid <= tree_valid && (tree_load != core_sched_pkg::LOAD_MAX);
        end
    end

    always_ff @(posedge clk) begin
        result_core_id <= tree_core_id;
        result_load    <= tree_load;
        result_app_id  <= tree_app_id;
        inc_core_id    <= tree_core_id;
    end

endmodule

`default_nettype wire

// File: src/min_tree.sv
`default_nettype none

module min_tree (
    input  wire                             clk,
    input  wire                             rst,

    input  wire                             dec_valid,
    input  wire core_sched_pkg::app_id_t    dec_app_id,
    input  wire core_sched_pkg::load_vec_t  dec_loads,

    output logic                            tree_valid,
    output core_sched_pkg::app_id_t         tree_app_id,
    output core_sched_pkg::core_id_t        tree_core_id,
    output core_sched_pkg::load_t           tree_load
);

    // level 1 nodes first, root last
    core_sched_pkg::load_t    node_load   [core_sched_pkg::CORE_COUNT-1];
    core_sched_pkg::core_id_t node_id     [core_sched_pkg::CORE_COUNT-1];
    core_sched_pkg::load_t    node_load_d [core_sched_pkg::CORE_COUNT-1];
    core_sched_pkg::core_id_t node_id_d   [core_sched_pkg::CORE_COUNT-1];

    logic [core_sched_pkg::TREE_LEVELS-1:0] valid_pipe;
    core_sched_pkg::app_id_t                app_pipe [core_sched_pkg::TREE_LEVELS];

    // each level only reads the registers of the level below
    always_comb begin
        int                       in_base;
        int                       out_base;
        core_sched_pkg::load_t    l_load;
        core_sched_pkg::load_t    r_load;
        core_sched_pkg::core_id_t l_id;
        core_sched_pkg::core_id_t r_id;

        in_base  = 0;
        out_base = 0;
        for (int lv = 1; lv <= core_sched_pkg::TREE_LEVELS; lv++) begin
            for (int nd = 0; nd < (core_sched_pkg::CORE_COUNT >> lv); nd++) begin
                if (lv == 1) begin
                    l_load = dec_loads[(2*nd)*core_sched_pkg::LOAD_W +: core_sched_pkg::LOAD_W];
                    r_load = dec_loads[(2*nd+1)*core_sched_pkg::LOAD_W +: core_sched_pkg::LOAD_W];
                    l_id   = core_sched_pkg::core_id_t'(2*nd);
                    r_id   = core_sched_pkg::core_id_t'(2*nd+1);
                end else begin
                    l_load = node_load[in_base+2*nd];
                    r_load = node_load[in_base+2*nd+1];
                    l_id   = node_id[in_base+2*nd];
                    r_id   = node_id[in_base+2*nd+1];
                end
                // left side always holds the lower indices, so ties stay left
                if (r_load < l_load) begin
                    node_load_d[out_base+nd] = r_load;
                    node_id_d[out_base+nd]   = r_id;
                end else begin
                    node_load_d[out_base+nd] = l_load;
                    node_id_d[out_base+nd]   = l_id;
                end
            end
            in_base  = out_base;
            out_base = out_base + (core_sched_pkg::CORE_COUNT >> lv);
        end
    end

    always_ff @(posedge clk) begin
        node_load <= node_load_d;
        node_id   <= node_id_d;
    end

    // request tag travels alongside the compares
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[core_sched_pkg::TREE_LEVELS-2:0], dec_valid};
        end
    end

    always_ff @(posedge clk) begin
        app_pipe[0] <= dec_app_id;
        for (int i = 1; i < core_sched_pkg::TREE_LEVELS; i++) begin
            app_pipe[i] <= app_pipe[i-1];
        end
    end

    assign tree_valid   = valid_pipe[core_sched_pkg::TREE_LEVELS-1];
    assign tree_app_id  = app_pipe[core_sched_pkg::TREE_LEVELS-1];
    assign tree_core_id = node_id[core_sched_pkg::CORE_COUNT-2];
    assign tree_load    = node_load[core_sched_pkg::CORE_COUNT-2];

    a_tree_valid_known: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(tree_valid)
    );

endmodule

`default_nettype wire

// File: src/request_decode.sv
`default_nettype none

module request_decode (
    input  wire                             clk,
    input  wire                             rst,

    input  wire                             req_en,
    input  wire core_sched_pkg::app_id_t    req_app_id,

    output core_sched_pkg::app_id_t         lookup_app_id,
    input  wire core_sched_pkg::core_mask_t lookup_mask,

    input  wire core_sched_pkg::load_vec_t  loads,

    output logic                            dec_valid,
    output core_sched_pkg::app_id_t         dec_app_id,
    output core_sched_pkg::load_vec_t       dec_loads
);

    logic                      req_q;
    core_sched_pkg::app_id_t   app_q;
    core_sched_pkg::load_vec_t loads_q;
    core_sched_pkg::load_vec_t masked;

    // capture edge, loads are frozen here for this request
    always_ff @(posedge clk) begin
        if (rst) begin
            req_q <= 1'b0;
        end else begin
            req_q <= req_en;
        end
    end

    always_ff @(posedge clk) begin
        if (req_en) begin
            app_q   <= req_app_id;
            loads_q <= loads;
        end
    end

    assign lookup_app_id = app_q;

    // disallowed cores read as the maximum load
    always_comb begin
        for (int c = 0; c < core_sched_pkg::CORE_COUNT; c++) begin
            masked[c*core_sched_pkg::LOAD_W +: core_sched_pkg::LOAD_W] =
                lookup_mask[c] ? loads_q[c*core_sched_pkg::LOAD_W +: core_sched_pkg::LOAD_W]
                               : core_sched_pkg::LOAD_MAX;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= req_q;
        end
    end

    always_ff @(posedge clk) begin
        dec_app_id <= app_q;
        dec_loads  <= masked;
    end

endmodule

`default_nettype wire

// File: src/core_load_state.sv
`default_nettype none

module core_load_state (
    input  wire                             clk,
    input  wire                             rst,

    input  wire                             core_ctl_valid,
    input  wire core_sched_pkg::core_id_t   core_ctl_core_id,
    input  wire                             core_ctl_activate,

    input  wire                             deq_valid,
    input  wire core_sched_pkg::core_id_t   deq_core_id,
    input  wire core_sched_pkg::load_t      deq_length,

    input  wire                             inc_valid,
    input  wire core_sched_pkg::core_id_t   inc_core_id,

    input  wire core_sched_pkg::load_t      rank_bound,

    output core_sched_pkg::load_vec_t       loads,
    output core_sched_pkg::core_mask_t      eligible
);

    core_sched_pkg::load_t      load_q [core_sched_pkg::CORE_COUNT];
    core_sched_pkg::load_t      load_d [core_sched_pkg::CORE_COUNT];
    core_sched_pkg::core_mask_t active_q;

    // increment and dequeue may hit the same core in one cycle
    always_comb begin
        logic [core_sched_pkg::LOAD_W+1:0] sum;

        for (int c = 0; c < core_sched_pkg::CORE_COUNT; c++) begin
            sum = {2'b00, load_q[c]};
            if (inc_valid && inc_core_id == core_sched_pkg::core_id_t'(c)) begin
                sum = sum + 1'b1;
            end
            if (deq_valid && deq_core_id == core_sched_pkg::core_id_t'(c)) begin
                sum = sum - {2'b00, deq_length};
            end
            // top bit set means the subtraction went below zero
            if (sum[core_sched_pkg::LOAD_W+1]) begin
                load_d[c] = '0;
            end else if (sum >= {2'b00, core_sched_pkg::LOAD_MAX}) begin
                load_d[c] = core_sched_pkg::LOAD_MAX - 1'b1;
            end else begin
                load_d[c] = sum[core_sched_pkg::LOAD_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active_q <= '0;
            for (int c = 0; c < core_sched_pkg::CORE_COUNT; c++) begin
                load_q[c] <= core_sched_pkg::LOAD_MAX;
            end
        end else begin
            for (int c = 0; c < core_sched_pkg::CORE_COUNT; c++) begin
                // core control wins over every other update
                if (core_ctl_valid && core_ctl_core_id == core_sched_pkg::core_id_t'(c)) begin
                    active_q[c] <= core_ctl_activate;
                    load_q[c]   <= core_ctl_activate ? '0 : core_sched_pkg::LOAD_MAX;
                end else if (active_q[c]) begin
                    load_q[c] <= load_d[c];
                end
            end
        end
    end

    always_comb begin
        for (int c = 0; c < core_sched_pkg::CORE_COUNT; c++) begin
            loads[c*core_sched_pkg::LOAD_W +: core_sched_pkg::LOAD_W] = load_q[c];
            eligible[c] = active_q[c] && (load_q[c] < rank_bound);
        end
    end

    // the result stage only picks cores that were active when sampled
    a_inc_active: assert property (
        @(posedge clk) disable iff (rst)
        inc_valid |-> active_q[inc_core_id]
    );

endmodule

`default_nettype wire

// File: src/app_table.sv
`default_nettype none

module app_table (
    input  wire                             clk,
    input  wire                             rst,

    input  wire                             cfg_valid,
    input  wire core_sched_pkg::app_id_t    cfg_app_id,
    input  wire core_sched_pkg::core_id_t   cfg_core_id,
    input  wire                             cfg_enable,

    input  wire core_sched_pkg::app_id_t    lookup_app_id,
    output core_sched_pkg::core_mask_t      lookup_mask,

    input  wire core_sched_pkg::core_mask_t eligible,
    output core_sched_pkg::app_mask_t       app_mask
);

    // allowed cores per application
    core_sched_pkg::core_mask_t core_mask [core_sched_pkg::APP_COUNT];

    // config writes touch one bit at a time
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int a = 0; a < core_sched_pkg::APP_COUNT; a++) begin
                core_mask[a] <= '0;
            end
        end else if (cfg_valid) begin
            core_mask[cfg_app_id][cfg_core_id] <= cfg_enable;
        end
    end

    // request lookup, read by the decode stage in the same cycle
    assign lookup_mask = core_mask[lookup_app_id];

    // an app is eligible when any of its allowed cores is
    always_ff @(posedge clk) begin
        if (rst) begin
            app_mask <= '0;
        end else begin
            for (int a = 0; a < core_sched_pkg::APP_COUNT; a++) begin
                app_mask[a] <= |(core_mask[a] & eligible);
            end
        end
    end

    // config strobe comes from outside, must be clean once out of reset
    a_cfg_valid_known: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(cfg_valid)
    );

endmodule

`default_nettype wire

// File: src/core_sched_pkg.sv
`default_nettype none

package core_sched_pkg;

    // core indexing
    localparam int CORE_ID_W = 4;
    localparam int CORE_COUNT = 1 << CORE_ID_W;

    // application indexing
    localparam int APP_ID_W = 3;
    localparam int APP_COUNT = 1 << APP_ID_W;

    // per-core load counters
    localparam int LOAD_W = 8;

    // one registered level per index bit
    localparam int TREE_LEVELS = CORE_ID_W;

    typedef logic [CORE_ID_W-1:0] core_id_t;

    typedef logic [APP_ID_W-1:0] app_id_t;

    typedef logic [LOAD_W-1:0] load_t;

    // one bit per core
    typedef logic [CORE_COUNT-1:0] core_mask_t;

    // one bit per application
    typedef logic [APP_COUNT-1:0] app_mask_t;

    // core 0 sits in the lowest field
    typedef logic [CORE_COUNT*LOAD_W-1:0] load_vec_t;

    // all ones marks an inactive or disallowed core
    localparam load_t LOAD_MAX = '1;

endpackage

`default_nettype wire
